// File: design/memStagePkg.sv
//--------------------
// shared types for the memory stage subsystem
// import with memStagePkg::* in the module header
// opNop and excNone encode as zero, so an all-zero record is a bubble
//--------------------
`default_nettype none

package memStagePkg;

    // data or address word
    typedef logic [31:0] word_t;

    // register number, r0 is never forwarded
    typedef logic [4:0] regAddr_t;

    // operations seen by the memory stage
    typedef enum logic [3:0] {
        opNop = 4'd0,
        opAlu = 4'd1,
        opLw  = 4'd2,
        opLh  = 4'd3,
        opLhu = 4'd4,
        opLb  = 4'd5,
        opLbu = 4'd6,
        opSw  = 4'd7,
        opSh  = 4'd8,
        opSb  = 4'd9
    } memOp_t;

    // address error codes
    typedef enum logic [1:0] {
        excNone = 2'd0,
        excAdEL = 2'd1,
        excAdES = 2'd2
    } excCode_t;

    // instruction record entering M
    typedef struct packed {
        memOp_t   op;
        word_t    pc;
        regAddr_t rtAddr;
        word_t    rtData;
        // effective address for loads and stores
        word_t    aluOut;
        logic     regWEn;
        regAddr_t regWAddr;
        word_t    regWData;
    } mStageIn_t;

    // request to the data memory, addr is word aligned
    typedef struct packed {
        word_t      addr;
        logic       rEn;
        logic       wEn;
        logic [3:0] byteEn;
        word_t      wData;
    } memReq_t;

    // contents of the M-to-W register
    typedef struct packed {
        memOp_t     op;
        word_t      pc;
        logic       regWEn;
        regAddr_t   regWAddr;
        word_t      regWData;
        logic [1:0] offset;
        word_t      memWord;
        excCode_t   exc;
    } wStageRec_t;

    // final writeback
    typedef struct packed {
        word_t    pc;
        logic     regWEn;
        regAddr_t regWAddr;
        word_t    regWData;
        excCode_t exc;
    } wbResult_t;

endpackage

`default_nettype wire

// File: design/memRequestGen.sv
//--------------------
// turns an M-stage instruction into a data memory request
// byte enables, lane shifted store data and address exceptions
// purely combinational
//--------------------
`timescale 1ns/1ps
`default_nettype none

module memRequestGen import memStagePkg::*; #(
    parameter word_t dmBase  = 32'h0000_1000,
    parameter int    dmWords = 256
) (
    input  mStageIn_t inst,
    input  word_t     storeData,
    output memReq_t   req,
    output excCode_t  exc
);

    // last byte address inside the window
    localparam word_t dmLast = dmBase + word_t'(dmWords * 4) - 1;

    word_t addr;
    logic  isLoad;
    logic  isStore;
    logic  isWord;
    logic  isHalf;
    logic  inWindow;
    logic  misaligned;
    logic  clean;

    assign addr = inst.aluOut;

    // opcode classes
    assign isLoad  = inst.op inside {opLw, opLh, opLhu, opLb, opLbu};
    assign isStore = inst.op inside {opSw, opSh, opSb};
    assign isWord  = inst.op inside {opLw, opSw};
    assign isHalf  = inst.op inside {opLh, opLhu, opSh};

    assign inWindow   = (addr >= dmBase) && (addr <= dmLast);
    assign misaligned = (isWord && (addr[1:0] != 2'b00)) || (isHalf && addr[0]);

    always_comb begin
        if (isLoad && (misaligned || !inWindow)) begin
            exc = excAdEL;
        end else if (isStore && (misaligned || !inWindow)) begin
            exc = excAdES;
        end else begin
            exc = excNone;
        end
    end

    assign clean = (exc == excNone);

    always_comb begin
        req.addr   = {addr[31:2], 2'b00};
        req.rEn    = isLoad && clean;
        req.wEn    = isStore && clean;
        req.byteEn = 4'b0000;
        req.wData  = '0;
        // lanes only matter for a store that will actually be issued
        if (req.wEn) begin
            case (inst.op)
                opSh: begin
                    req.byteEn = addr[1] ? 4'b1100 : 4'b0011;
                    req.wData  = storeData << {addr[1], 4'b0000};
                end
                opSb: begin
                    req.byteEn = 4'b0001 << addr[1:0];
                    req.wData  = storeData << {addr[1:0], 3'b000};
                end
                default: begin
                    req.byteEn = 4'b1111;
                    req.wData  = storeData;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/dataMemory.sv
//--------------------
// byte enabled data memory with a fixed access latency
// ready rises in the accessLatency-th cycle of a held request
// writes land on the clock edge where ready is high
//--------------------
`timescale 1ns/1ps
`default_nettype none

module dataMemory import memStagePkg::*; #(
    parameter word_t dmBase        = 32'h0000_1000,
    parameter int    dmWords       = 256,
    parameter int    accessLatency = 3
) (
    input  logic    clk,
    input  logic    reset,
    input  memReq_t req,
    output word_t   rData,
    output logic    ready
);

    localparam int idxW = (dmWords > 1) ? $clog2(dmWords) : 1;
    localparam int cntW = (accessLatency > 1) ? $clog2(accessLatency) : 1;

    word_t mem [dmWords];

    word_t            byteOffset;
    logic [idxW-1:0]  idx;
    logic [cntW-1:0]  count;
    logic             active;

    // word index relative to the window base
    assign byteOffset = req.addr - dmBase;
    assign idx        = idxW'(byteOffset >> 2);

    assign active = req.rEn | req.wEn;
    assign ready  = active && (count == cntW'(accessLatency - 1));

    // latency counter, restarts after every completed access
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (!active || ready) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (req.wEn && ready) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (req.byteEn[lane]) begin
                    mem[idx][8*lane +: 8] <= req.wData[8*lane +: 8];
                end
            end
        end
    end

    // data only presented on the completing cycle
    assign rData = ready ? mem[idx] : '0;

endmodule

`default_nettype wire

// File: design/memStage.sv
//--------------------
// memory pipeline stage with its data memory
// forwards the W result into store data, stalls on memory busy
// and owns the M-to-W register
// the driver must hold mIn stable while busy is high
//--------------------
`timescale 1ns/1ps
`default_nettype none

module memStage import memStagePkg::*; #(
    parameter word_t dmBase        = 32'h0000_1000,
    parameter int    dmWords       = 256,
    parameter int    accessLatency = 3
) (
    input  logic       clk,
    input  logic       reset,
    input  mStageIn_t  mIn,
    input  logic       clear,
    output wStageRec_t wRec,
    output logic       busy
);

    mStageIn_t  genInst;
    word_t      storeData;
    memReq_t    req;
    excCode_t   exc;
    word_t      rData;
    logic       ready;
    wStageRec_t nextRec;

    // W to M bypass of the rt value, r0 excluded
    always_comb begin
        if (wRec.regWEn && (wRec.regWAddr != '0) && (wRec.regWAddr == mIn.rtAddr)) begin
            storeData = wRec.regWData;
        end else begin
            storeData = mIn.rtData;
        end
    end

    // a flushed instruction makes no memory access
    always_comb begin
        genInst = mIn;
        if (clear) begin
            genInst.op = opNop;
        end
    end

    memRequestGen #(
        .dmBase  (dmBase),
        .dmWords (dmWords)
    ) reqGen (
        .inst      (genInst),
        .storeData (storeData),
        .req       (req),
        .exc       (exc)
    );

    dataMemory #(
        .dmBase        (dmBase),
        .dmWords       (dmWords),
        .accessLatency (accessLatency)
    ) dmem (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .rData (rData),
        .ready (ready)
    );

    assign busy = (req.rEn | req.wEn) & ~ready;

    always_comb begin
        nextRec.op       = mIn.op;
        nextRec.pc       = mIn.pc;
        nextRec.regWEn   = mIn.regWEn;
        nextRec.regWAddr = mIn.regWAddr;
        nextRec.regWData = mIn.regWData;
        nextRec.offset   = mIn.aluOut[1:0];
        nextRec.memWord  = rData;
        nextRec.exc      = exc;
    end

    // stall wins over clear
    always_ff @(posedge clk) begin
        if (reset) begin
            wRec <= '0;
        end else if (!busy) begin
            if (clear) begin
                wRec <= '0;
            end else begin
                wRec <= nextRec;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/loadAlign.sv
//--------------------
// writeback side load alignment
// picks the loaded lane and sign or zero extends it
// combinational, sits after the M-to-W register
//--------------------
`timescale 1ns/1ps
`default_nettype none

module loadAlign import memStagePkg::*; (
    input  wStageRec_t wRec,
    output wbResult_t  wb
);

    logic [15:0] half;
    logic [7:0]  lane;

    assign half = wRec.offset[1] ? wRec.memWord[31:16] : wRec.memWord[15:0];
    assign lane = wRec.memWord[8*wRec.offset +: 8];

    always_comb begin
        wb.pc       = wRec.pc;
        wb.regWAddr = wRec.regWAddr;
        wb.exc      = wRec.exc;
        // an excepting instruction never writes the register file
        wb.regWEn   = wRec.regWEn && (wRec.exc == excNone);
        case (wRec.op)
            opLw:    wb.regWData = wRec.memWord;
            opLh:    wb.regWData = {{16{half[15]}}, half};
            opLhu:   wb.regWData = {16'h0000, half};
            opLb:    wb.regWData = {{24{lane[7]}}, lane};
            opLbu:   wb.regWData = {24'h000000, lane};
            default: wb.regWData = wRec.regWData;
        endcase
    end

endmodule

`default_nettype wire

// File: design/memSubsystemTop.sv
//--------------------
// top of the memory subsystem
// memory stage followed by the load aligner
// sets the data memory window and access latency
//--------------------
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTop import memStagePkg::*; #(
    parameter word_t dmBase        = 32'h0000_1000,
    parameter int    dmWords       = 256,
    parameter int    accessLatency = 3
) (
    input  logic      clk,
    input  logic      reset,
    input  mStageIn_t mIn,
    input  logic      clear,
    output wbResult_t wb,
    output logic      busy
);

    wStageRec_t wRec;

    memStage #(
        .dmBase        (dmBase),
        .dmWords       (dmWords),
        .accessLatency (accessLatency)
    ) mStage (
        .clk   (clk),
        .reset (reset),
        .mIn   (mIn),
        .clear (clear),
        .wRec  (wRec),
        .busy  (busy)
    );

    loadAlign align (
        .wRec (wRec),
        .wb   (wb)
    );

endmodule

`default_nettype wire

// File: tests/memSubsystem_properties.sv
//--------------------
// assertions for the memory stage, bound into memStage
// busy after reset, W register hold while stalled, byte enable legality
//--------------------
`timescale 1ns/1ps
`default_nettype none

module memSubsystem_properties import memStagePkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       busy,
    input memReq_t    req,
    input wStageRec_t wRec
);

    // no access can be pending right after reset
    busyAfterReset: assert property (@(posedge clk) reset |=> !busy)
        else $error("busy is high in the cycle after reset");

    // a stalled stage keeps its W record
    holdWhileBusy: assert property (@(posedge clk) disable iff (reset) busy |=> $stable(wRec))
        else $error("W register changed while busy");

    // reads and idle cycles carry no lanes
    byteEnLegal: assert property (@(posedge clk) !req.wEn |-> (req.byteEn == 4'b0000))
        else $error("byte enables set without a write");

endmodule

bind memStage memSubsystem_properties props (
    .clk   (clk),
    .reset (reset),
    .busy  (busy),
    .req   (req),
    .wRec  (wRec)
);

`default_nettype wire

// File: tests/memSubsystemTb.sv
//--------------------
// testbench for the memory subsystem
// replays the test data with random bubbles between instructions
// checks every wb record and the busy timing, run from the project root
//--------------------
`timescale 1ns/1ps
`default_nettype none

module memSubsystemTb import memStagePkg::*; ();

    localparam word_t dmBase        = 32'h0000_1000;
    localparam int    dmWords       = 256;
    localparam int    accessLatency = 3;

    logic        clk;
    logic        reset;
    logic        clear;
    mStageIn_t   mIn;
    wbResult_t   wb;
    logic        busy;

    mStageIn_t   instQ[$];
    logic        clearQ[$];
    logic        noGapQ[$];
    wbResult_t   expectQ[$];
    // accepted instructions whose result is due on wb
    wbResult_t   pendingQ[$];

    int          wbErrors = 0;
    int          busyErrors = 0;
    int          otherErrors = 0;
    int          testCount = 0;
    logic        loaded = 1'b0;
    logic [15:0] lfsr = 16'd64710;

    memSubsystemTop #(
        .dmBase        (dmBase),
        .dmWords       (dmWords),
        .accessLatency (accessLatency)
    ) dut (
        .clk   (clk),
        .reset (reset),
        .mIn   (mIn),
        .clear (clear),
        .wb    (wb),
        .busy  (busy)
    );

    always #2 clk = ~clk;

    // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsrStep(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    function automatic int drawBits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsrStep(lfsr);
        end
        return value;
    endfunction

    // loads and stores that pass the address checks reach the memory
    function automatic logic isAccess(input memOp_t op, input logic clr, input excCode_t exc);
        return !clr && (exc == excNone) &&
               (op inside {opLw, opLh, opLhu, opLb, opLbu, opSw, opSh, opSb});
    endfunction

    task automatic checkWb(input wbResult_t expected);
        if (wb !== expected) begin
            wbErrors++;
            $display("mismatch at %0t: wb expected %h got %h", $time, expected, wb);
        end
    endtask

    task automatic checkBusy(input logic expected);
        if (busy !== expected) begin
            busyErrors++;
            $display("mismatch at %0t: busy expected %b got %b", $time, expected, busy);
        end
    endtask

    task automatic loadTests();
        int        fd;
        string     line;
        word_t     col [14];
        mStageIn_t inst;
        wbResult_t expected;
        fd = $fopen("tests/memSubsystem_testdata.txt", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("could not open the test data file");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                        col[7], col[8], col[9], col[10], col[11], col[12], col[13]) != 14) begin
                otherErrors++;
                $display("malformed test data line: %s", line);
                continue;
            end
            inst.op           = memOp_t'(col[0][3:0]);
            inst.pc           = col[1];
            inst.rtAddr       = col[2][4:0];
            inst.rtData       = col[3];
            inst.aluOut       = col[4];
            inst.regWEn       = col[5][0];
            inst.regWAddr     = col[6][4:0];
            inst.regWData     = col[7];
            expected.pc       = col[1];
            expected.regWEn   = col[10][0];
            expected.regWAddr = col[11][4:0];
            expected.regWData = col[12];
            expected.exc      = excCode_t'(col[13][1:0]);
            // a flushed slot leaves an empty record behind
            if (col[8][0]) begin
                expected = '0;
            end
            instQ.push_back(inst);
            clearQ.push_back(col[8][0]);
            noGapQ.push_back(col[9][0]);
            expectQ.push_back(expected);
        end
        $fclose(fd);
        if (instQ.size() == 0) begin
            otherErrors++;
            $display("no test vectors were read");
        end
    endtask

    // called right after a rising edge, returns on the edge that accepts inst
    task automatic presentInst(input mStageIn_t inst, input logic clr,
                               input wbResult_t expected, input int busyCycles);
        int waited;
        waited = 0;
        mIn   <= inst;
        clear <= clr;
        @(negedge clk);
        // result of the instruction accepted on the edge just passed
        if (pendingQ.size() > 0) begin
            checkWb(pendingQ.pop_front());
        end
        checkBusy(waited < busyCycles);
        while (busy) begin
            waited++;
            @(negedge clk);
            checkBusy(waited < busyCycles);
        end
        pendingQ.push_back(expected);
        @(posedge clk);
    endtask

    task automatic printCounts();
        $display("errors: wb %0d, busy %0d, other %0d", wbErrors, busyErrors, otherErrors);
    endtask

    initial begin
        int busyCycles;
        int bubbles;
        clk   = 1'b0;
        reset = 1'b1;
        clear = 1'b0;
        mIn   = '0;
        loadTests();
        testCount = instQ.size();
        loaded    = 1'b1;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        checkWb('0);
        checkBusy(1'b0);
        @(posedge clk);
        for (int i = 0; i < testCount; i++) begin
            // forwarding pairs must stay back to back
            if (!noGapQ[i]) begin
                bubbles = drawBits(2);
                repeat (bubbles) presentInst('0, 1'b0, '0, 0);
            end
            busyCycles = isAccess(instQ[i].op, clearQ[i], expectQ[i].exc) ? accessLatency - 1 : 0;
            presentInst(instQ[i], clearQ[i], expectQ[i], busyCycles);
        end
        mIn   <= '0;
        clear <= 1'b0;
        @(negedge clk);
        if (pendingQ.size() > 0) begin
            checkWb(pendingQ.pop_front());
        end
        printCounts();
        if (wbErrors + busyErrors + otherErrors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // watchdog, sized from the number of test lines
    initial begin
        wait (loaded);
        repeat (testCount * (accessLatency + 5) + 50) @(posedge clk);
        $display("timeout: the run did not complete in time");
        printCounts();
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/memSubsystem_testdata.txt
# op pc rtAddr rtData aluOut regWEn regWAddr regWData clear noGap (hex, op 0=nop 1=alu 2..6=loads 7..9=stores)
# then expected wb: regWEn regWAddr regWData exc (1=AdEL 2=AdES), wb pc follows the instruction
7 00400000 01 11223344 00001000 0 00 00000000 0 0 0 00 00000000 0
8 00400004 02 0000AABB 00001002 0 00 00000000 0 0 0 00 00000000 0
9 00400008 03 000000C5 00001001 0 00 00000000 0 0 0 00 00000000 0
9 0040000C 03 000000F0 00001000 0 00 00000000 0 0 0 00 00000000 0
2 00400010 00 00000000 00001000 1 08 00000000 0 0 1 08 AABBC5F0 0
3 00400014 00 00000000 00001002 1 09 00000000 0 0 1 09 FFFFAABB 0
4 00400018 00 00000000 00001000 1 0A 00000000 0 0 1 0A 0000C5F0 0
5 0040001C 00 00000000 00001001 1 0B 00000000 0 0 1 0B FFFFFFC5 0
6 00400020 00 00000000 00001003 1 0C 00000000 0 0 1 0C 000000AA 0
7 00400024 04 DEADBEEF 00001004 0 00 00000000 0 0 0 00 00000000 0
8 00400028 05 12345678 00001004 0 00 00000000 0 0 0 00 00000000 0
9 0040002C 06 0000007E 00001006 0 00 00000000 0 0 0 00 00000000 0
9 00400030 06 00000081 00001007 0 00 00000000 0 0 0 00 00000000 0
5 00400034 00 00000000 00001006 1 0D 00000000 0 0 1 0D 0000007E 0
2 00400038 00 00000000 00001004 1 0E 00000000 0 0 1 0E 817E5678 0
2 0040003C 00 00000000 00001002 1 0F 00000000 0 0 0 0F 00000000 1
8 00400040 07 0000FFFF 00001005 0 00 00000000 0 0 0 00 00000000 2
7 00400044 07 99999999 00002000 0 00 00000000 0 0 0 00 00000000 2
5 00400048 00 00000000 00000FFF 1 10 00000000 0 0 0 10 00000000 1
2 0040004C 00 00000000 00001004 1 11 00000000 0 0 1 11 817E5678 0
2 00400050 00 00000000 00001000 1 12 00000000 0 0 1 12 AABBC5F0 0
1 00400054 00 00000000 00000000 1 17 5A5A1234 0 0 1 17 5A5A1234 0
7 00400058 17 00000BAD 00001008 0 00 00000000 0 1 0 00 00000000 0
1 0040005C 00 00000000 00000000 1 00 77777777 0 0 1 00 77777777 0
7 00400060 00 0000C0DE 0000100C 0 00 00000000 0 1 0 00 00000000 0
2 00400064 00 00000000 00001008 1 13 00000000 0 0 1 13 5A5A1234 0
2 00400068 00 00000000 0000100C 1 14 00000000 0 0 1 14 0000C0DE 0
2 0040006C 00 00000000 00001008 1 15 00000000 1 0 0 00 00000000 0
2 00400070 00 00000000 00001008 1 16 00000000 0 1 1 16 5A5A1234 0

// File: project.f
design/memStagePkg.sv
design/memRequestGen.sv
design/dataMemory.sv
design/memStage.sv
design/loadAlign.sv
design/memSubsystemTop.sv
tests/memSubsystem_properties.sv
tests/memSubsystemTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= memSubsystemTb
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell cat $(FILELIST))
SIMBIN  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIMBIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIMBIN)
	./$(SIMBIN) 2>&1 | tee $(LOG)
	@if grep -q "Testbench failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "Testbench passed" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
